//--- sdcard_pkg.sv
`default_nettype none

package sdcard_pkg;

   // Register addresses on the bus.
   typedef enum logic [3:0] {
      reg_ctrl = 4'd0,
      reg_crc  = 4'd1
   } sdcard_reg_t;

   // Transfer engine states.
   // The low and high states follow the sck level.
   typedef enum logic [1:0] {
      st_idle,
      st_low,
      st_high
   } spi_state_t;

   // Width of the sck divider.
   localparam int div_width = 8;

   // Number of card slots on the bus and the ports.
   localparam int num_slots_max = 2;

endpackage

`default_nettype wire

//--- sdcard_spi_engine.sv
`timescale 1ns/10ps
`default_nettype none

module sdcard_spi_engine (
   input  wire                                clk,
   input  wire                                reset,
   input  wire                                start,
   input  wire                                busy_req,
   input  wire                                wait_req,
   input  wire  [0:sdcard_pkg::div_width-1]   divider,
   input  wire                                load,
   input  wire  [0:7]                         out_byte,
   input  wire                                miso_s,
   output logic                               busy,
   output logic                               sck,
   output logic                               mosi,
   output logic                               bit_tick,
   output logic [0:7]                         in_byte
);

   sdcard_pkg::spi_state_t state;

   logic [0:sdcard_pkg::div_width-1] cyc_cnt;
   logic [0:2] bit_cnt;
   logic [0:7] sr_out;
   logic cyc_done;
   logic last_bit;
   logic hold;

   assign cyc_done = (cyc_cnt == divider);
   assign busy = (state != sdcard_pkg::st_idle);
   assign sck = (state == sdcard_pkg::st_high);

   // A bit is sampled as sck falls.
   assign bit_tick = sck && cyc_done;

   assign mosi = sr_out[0];
   assign last_bit = (bit_cnt == 3'd7);

   // In wait mode the count stays at zero until the card drives a 0.
   assign hold = wait_req && (bit_cnt == 3'd0) && miso_s;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= sdcard_pkg::st_idle;
         cyc_cnt <= '0;
         bit_cnt <= 3'd0;
      end else if (start) begin
         state <= busy_req ? sdcard_pkg::st_low : sdcard_pkg::st_idle;
         cyc_cnt <= '0;
         bit_cnt <= 3'd0;
      end else if (busy) begin
         if (cyc_done) begin
            cyc_cnt <= '0;
            case (state)
               sdcard_pkg::st_low: begin
                  state <= sdcard_pkg::st_high;
               end
               sdcard_pkg::st_high: begin
                  if (last_bit) begin
                     state <= sdcard_pkg::st_idle;
                  end else begin
                     state <= sdcard_pkg::st_low;
                  end
                  if (!last_bit && !hold) begin
                     bit_cnt <= bit_cnt + 3'd1;
                  end
               end
               default: begin
                  state <= sdcard_pkg::st_idle;
               end
            endcase
         end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
         end
      end
   end

   // A bus load wins over the shift.
   always_ff @(posedge clk) begin
      if (reset) begin
         sr_out <= 8'h00;
      end else if (load) begin
         sr_out <= out_byte;
      end else if (bit_tick) begin
         sr_out <= {sr_out[1:7], 1'b1};
      end
   end

   always_ff @(posedge clk) begin
      if (bit_tick) begin
         in_byte <= {in_byte[1:7], miso_s};
      end
   end

   // Once idle, sck cannot rise on the next cycle.
   idle_sck_low: assert property (@(posedge clk) disable iff (reset)
      !busy |=> !sck);

   // Ticks land on the high phase and sck falls right after.
   tick_on_fall: assert property (@(posedge clk) disable iff (reset)
      bit_tick |-> sck ##1 !sck);

endmodule

`default_nettype wire

//--- sdcard_crc.sv
`timescale 1ns/10ps
`default_nettype none

module sdcard_crc (
   input  wire         clk,
   input  wire         reset,
   input  wire         bit_tick,
   input  wire         mosi,
   input  wire         miso_s,
   input  wire         crc7_clear,
   input  wire         crc16_clear_hi,
   input  wire         crc16_clear_lo,
   input  wire         crc16_src_load,
   input  wire         crc16_src,
   output logic [0:6]  crc7,
   output logic [0:15] crc16
);

   logic src_is_mosi;
   logic crc7_x;
   logic crc16_x;

   assign crc7_x = crc7[0] ^ mosi;
   assign crc16_x = crc16[0] ^ (src_is_mosi ? mosi : miso_s);

   // x7 + x3 + 1.
   always_ff @(posedge clk) begin
      if (reset) begin
         crc7 <= 7'd0;
      end else if (crc7_clear) begin
         crc7 <= 7'd0;
      end else if (bit_tick) begin
         crc7 <= {crc7[1:6], 1'b0} ^ {3'b000, crc7_x, 2'b00, crc7_x};
      end
   end

   // The CRC16 uses x16 + x12 + x5 + 1. Byte clears take priority over the step.
   always_ff @(posedge clk) begin
      if (reset) begin
         crc16 <= 16'h0000;
      end else begin
         if (bit_tick) begin
            crc16 <= {crc16[1:15], 1'b0} ^
                     {3'b000, crc16_x, 6'b000000, crc16_x, 4'b0000, crc16_x};
         end
         if (crc16_clear_hi) begin
            crc16[0:7] <= 8'h00;
         end
         if (crc16_clear_lo) begin
            crc16[8:15] <= 8'h00;
         end
      end
   end

   // A 1 in the source select means mosi.
   always_ff @(posedge clk) begin
      if (reset) begin
         src_is_mosi <= 1'b0;
      end else if (crc16_src_load) begin
         src_is_mosi <= crc16_src;
      end
   end

endmodule

`default_nettype wire

//--- sdcard_detect.sv
`timescale 1ns/10ps
`default_nettype none

module sdcard_detect (
   input  wire                                    clk,
   input  wire                                    reset,
   input  wire  [0:sdcard_pkg::num_slots_max-1]   sdcard_cd,
   input  wire  [0:sdcard_pkg::num_slots_max-1]   sdcard_wp,
   input  wire                                    sdcard_miso,
   input  wire  [0:sdcard_pkg::num_slots_max-1]   clr_inserted,
   input  wire  [0:sdcard_pkg::num_slots_max-1]   clr_removed,
   output logic [0:sdcard_pkg::num_slots_max-1]   cd_sync,
   output logic [0:sdcard_pkg::num_slots_max-1]   wp_sync,
   output logic [0:sdcard_pkg::num_slots_max-1]   inserted,
   output logic [0:sdcard_pkg::num_slots_max-1]   removed,
   output logic                                   miso_s
);

   logic [0:sdcard_pkg::num_slots_max-1] cd_meta;
   logic [0:sdcard_pkg::num_slots_max-1] cd_mid;
   logic [0:sdcard_pkg::num_slots_max-1] cd_rise;
   logic [0:sdcard_pkg::num_slots_max-1] cd_fall;

   // Card detect goes through three stages. The last one gives the stable level.
   always_ff @(posedge clk) begin
      cd_meta <= sdcard_cd;
      cd_mid <= cd_meta;
      cd_sync <= cd_mid;
      wp_sync <= sdcard_wp;
      miso_s <= sdcard_miso;
   end

   assign cd_rise = cd_mid & ~cd_sync;
   assign cd_fall = cd_sync & ~cd_mid;

   // Sticky until the host writes a 1 to the flag.
   always_ff @(posedge clk) begin
      if (reset) begin
         inserted <= '0;
         removed <= '0;
      end else begin
         inserted <= (inserted | cd_rise) & ~clr_inserted;
         removed <= (removed | cd_fall) & ~clr_removed;
      end
   end

endmodule

`default_nettype wire

//--- sdcard_regs.sv
`timescale 1ns/10ps
`default_nettype none

module sdcard_regs #(
   parameter int num_sdcard = 1
) (
   input  wire                                    clk,
   input  wire                                    reset,
   input  wire  [0:3]                             adr,
   input  wire                                    cs,
   input  wire  [0:3]                             sel,
   input  wire                                    we,
   input  wire  [0:31]                            d,
   output logic [0:31]                            q,
   output logic                                   start,
   output logic                                   busy_req,
   output logic                                   wait_req,
   output logic [0:sdcard_pkg::div_width-1]       divider,
   output logic                                   load,
   output logic [0:7]                             out_byte,
   output logic                                   crc7_clear,
   output logic                                   crc16_clear_hi,
   output logic                                   crc16_clear_lo,
   output logic                                   crc16_src_load,
   output logic                                   crc16_src,
   output logic [0:sdcard_pkg::num_slots_max-1]   clr_inserted,
   output logic [0:sdcard_pkg::num_slots_max-1]   clr_removed,
   output logic                                   sdcard_select,
   output logic                                   sdcard_cs,
   input  wire                                    busy,
   input  wire  [0:7]                             in_byte,
   input  wire  [0:6]                             crc7,
   input  wire  [0:15]                            crc16,
   input  wire  [0:sdcard_pkg::num_slots_max-1]   cd_sync,
   input  wire  [0:sdcard_pkg::num_slots_max-1]   wp_sync,
   input  wire  [0:sdcard_pkg::num_slots_max-1]   inserted,
   input  wire  [0:sdcard_pkg::num_slots_max-1]   removed
);

   logic wr_en;
   logic [0:3] wr_ctrl;
   logic [0:3] wr_crc;

   // Per-lane write strobes for each register.
   assign wr_en = cs && we;
   assign wr_ctrl = (wr_en && adr == sdcard_pkg::reg_ctrl) ? sel : 4'b0000;
   assign wr_crc = (wr_en && adr == sdcard_pkg::reg_crc) ? sel : 4'b0000;

   // Lane 2 of the control word starts or stops the engine.
   assign start = wr_ctrl[2];
   assign busy_req = d[23];
   assign load = wr_ctrl[3];
   assign out_byte = d[24:31];

   // A new frame starts when chip-select was low.
   assign crc7_clear = wr_ctrl[2] && !sdcard_cs;
   assign crc16_clear_hi = wr_crc[2];
   assign crc16_clear_lo = wr_crc[3];
   assign crc16_src_load = wr_crc[3];
   assign crc16_src = d[31];

   assign clr_inserted = wr_ctrl[1] ? {d[8], d[12]} : '0;
   assign clr_removed = wr_ctrl[1] ? {d[9], d[13]} : '0;

   always_ff @(posedge clk) begin
      if (reset) begin
         divider <= 8'hff;
         sdcard_cs <= 1'b0;
         wait_req <= 1'b0;
         sdcard_select <= 1'b0;
      end else begin
         if (wr_ctrl[0]) begin
            divider <= d[0:7];
         end
         if (wr_ctrl[2]) begin
            sdcard_cs <= d[19];
            wait_req <= d[22];
         end
         if (wr_crc[1] && num_sdcard > 1) begin
            sdcard_select <= d[15];
         end
      end
   end

   always_comb begin
      q = 32'h00000000;
      case (sdcard_pkg::sdcard_reg_t'(adr))
         sdcard_pkg::reg_ctrl: begin
            q[0:7] = divider;
            q[8:11] = {inserted[0], removed[0], wp_sync[0], cd_sync[0]};
            q[12:15] = {inserted[1], removed[1], wp_sync[1], cd_sync[1]};
            q[19] = sdcard_cs;
            q[22] = wait_req;
            q[23] = busy;
            q[24:31] = in_byte;
         end
         sdcard_pkg::reg_crc: begin
            // The CRC7 with its end bit is ready to send.
            q[0:7] = {crc7, 1'b1};
            q[8:11] = 4'(num_sdcard);
            q[15] = sdcard_select;
            q[16:31] = crc16;
         end
         default: begin
            q = 32'h00000000;
         end
      endcase
   end

   single_slot_select: assert property (@(posedge clk) disable iff (reset)
      (num_sdcard == 1) |-> !sdcard_select);

endmodule

`default_nettype wire

//--- sdcard_host.sv
`timescale 1ns/10ps
`default_nettype none

module sdcard_host #(
   parameter int num_sdcard = 1
) (
   input  wire                                    clk,
   input  wire                                    reset,
   input  wire  [0:3]                             adr,
   input  wire                                    cs,
   input  wire  [0:3]                             sel,
   input  wire                                    we,
   input  wire  [0:31]                            d,
   output logic [0:31]                            q,
   output logic                                   sdcard_select,
   output logic                                   sdcard_cs,
   input  wire  [0:sdcard_pkg::num_slots_max-1]   sdcard_cd,
   input  wire  [0:sdcard_pkg::num_slots_max-1]   sdcard_wp,
   output logic                                   sdcard_sck,
   input  wire                                    sdcard_miso,
   output logic                                   sdcard_mosi
);

   logic start;
   logic busy_req;
   logic wait_req;
   logic [0:sdcard_pkg::div_width-1] divider;
   logic load;
   logic [0:7] out_byte;
   logic busy;
   logic bit_tick;
   logic [0:7] in_byte;
   logic miso_s;
   logic crc7_clear;
   logic crc16_clear_hi;
   logic crc16_clear_lo;
   logic crc16_src_load;
   logic crc16_src;
   logic [0:6] crc7;
   logic [0:15] crc16;
   logic [0:sdcard_pkg::num_slots_max-1] clr_inserted;
   logic [0:sdcard_pkg::num_slots_max-1] clr_removed;
   logic [0:sdcard_pkg::num_slots_max-1] cd_sync;
   logic [0:sdcard_pkg::num_slots_max-1] wp_sync;
   logic [0:sdcard_pkg::num_slots_max-1] inserted;
   logic [0:sdcard_pkg::num_slots_max-1] removed;

   sdcard_regs #(.num_sdcard(num_sdcard)) regs_i (
      .clk, .reset, .adr, .cs, .sel, .we, .d, .q,
      .start, .busy_req, .wait_req, .divider, .load, .out_byte,
      .crc7_clear, .crc16_clear_hi, .crc16_clear_lo, .crc16_src_load, .crc16_src,
      .clr_inserted, .clr_removed, .sdcard_select, .sdcard_cs,
      .busy, .in_byte, .crc7, .crc16, .cd_sync, .wp_sync, .inserted, .removed
   );

   sdcard_spi_engine engine_i (
      .clk, .reset, .start, .busy_req, .wait_req, .divider, .load, .out_byte,
      .miso_s, .busy, .sck(sdcard_sck), .mosi(sdcard_mosi), .bit_tick, .in_byte
   );

   // The CRC steps on the same bit as the engine, before the shift.
   sdcard_crc crc_i (
      .clk, .reset, .bit_tick, .mosi(sdcard_mosi), .miso_s,
      .crc7_clear, .crc16_clear_hi, .crc16_clear_lo, .crc16_src_load, .crc16_src,
      .crc7, .crc16
   );

   sdcard_detect detect_i (
      .clk, .reset, .sdcard_cd, .sdcard_wp, .sdcard_miso,
      .clr_inserted, .clr_removed, .cd_sync, .wp_sync, .inserted, .removed, .miso_s
   );

endmodule

`default_nettype wire

//--- tb_sdcard_host.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sdcard_host;

   localparam int num_sdcard = 2;
   localparam logic [7:0] xfer_div = 8'd2;
   // Longest transfer is 13 bits of 6 cycles, plus the bus reads around it.
   localparam int xfer_cycles = 100;
   localparam int num_xfers = 20;
   localparam int watchdog_cycles = 20 * num_xfers * xfer_cycles;
   localparam int max_busy_reads = 200;

   logic clk = 1'b0;
   logic reset;
   logic [0:3] adr;
   logic cs;
   logic [0:3] sel;
   logic we;
   logic [0:31] d;
   logic [0:1] sdcard_cd;
   logic [0:1] sdcard_wp;
   logic sdcard_miso = 1'b1;
   wire [0:31] q;
   wire sdcard_select;
   wire sdcard_cs;
   wire sdcard_sck;
   wire sdcard_mosi;

   integer seed;
   int errors = 0;

   // Card model state.
   logic miso_q[$];
   logic sck_seen = 1'b0;
   logic mosi_hold = 1'b0;
   logic [7:0] sent_shift = 8'h00;
   int sck_pulses = 0;

   sdcard_host #(.num_sdcard(num_sdcard)) sdcard_host_i (
      .clk, .reset, .adr, .cs, .sel, .we, .d, .q,
      .sdcard_select, .sdcard_cs, .sdcard_cd, .sdcard_wp,
      .sdcard_sck, .sdcard_miso, .sdcard_mosi
   );

   always #50 clk = ~clk;

   // The card takes mosi while sck is high and moves to its next miso bit once sck falls.
   always @(posedge clk) begin
      #1;
      if (sck_seen && !sdcard_sck) begin
         sent_shift = {sent_shift[6:0], mosi_hold};
         sck_pulses = sck_pulses + 1;
         if (miso_q.size() > 0) begin
            void'(miso_q.pop_front());
         end
      end
      if (sdcard_sck) begin
         mosi_hold = sdcard_mosi;
      end
      sck_seen = sdcard_sck;
      sdcard_miso = (miso_q.size() > 0) ? miso_q[0] : 1'b1;
   end

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("Watchdog expired after %0d cycles without the tests finishing", watchdog_cycles);
      $display("Simulation failed");
      $fatal(1, "Run stopped by the watchdog");
   end

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] expected);
      if (got !== expected) begin
         errors++;
         $display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
         $display("Simulation failed");
         $fatal(1, "Stopped at the first error");
      end
   endtask

   task automatic bus_write(input logic [0:3] a, input logic [0:3] lanes, input logic [0:31] data);
      @(posedge clk);
      #1;
      adr = a;
      sel = lanes;
      d = data;
      cs = 1'b1;
      we = 1'b1;
      @(posedge clk);
      #1;
      cs = 1'b0;
      we = 1'b0;
      sel = 4'b0000;
   endtask

   // Reads are combinational, so q is taken in the low half of the cycle.
   task automatic bus_read(input logic [0:3] a, output logic [0:31] data);
      @(posedge clk);
      #1;
      adr = a;
      @(negedge clk);
      data = q;
   endtask

   task automatic xfer_byte(input logic [7:0] tx, input logic [7:0] reply, input int lead,
                            input logic wait_mode, output logic [7:0] rx);
      logic [0:31] w;
      logic [0:31] r;
      int pulses_before;
      int reads;
      miso_q.delete();
      for (int i = 0; i < lead; i++) begin
         miso_q.push_back(1'b1);
      end
      for (int i = 7; i >= 0; i--) begin
         miso_q.push_back(reply[i]);
      end
      pulses_before = sck_pulses;
      w = '0;
      w[0:7] = xfer_div;
      w[19] = 1'b1;
      w[22] = wait_mode;
      w[23] = 1'b1;
      w[24:31] = tx;
      bus_write(sdcard_pkg::reg_ctrl, 4'b1011, w);
      reads = 0;
      bus_read(sdcard_pkg::reg_ctrl, r);
      while (r[23] && reads < max_busy_reads) begin
         bus_read(sdcard_pkg::reg_ctrl, r);
         reads++;
      end
      if (r[23]) begin
         $display("Transfer did not finish, busy still set after %0d reads", max_busy_reads);
         $display("Simulation failed");
         $fatal(1, "Transfer hung");
      end
      check("sck pulses", sck_pulses - pulses_before, wait_mode ? lead + 8 : 8);
      check("sck idle", sdcard_sck, 1'b0);
      check("cs pin during transfer", sdcard_cs, 1'b1);
      rx = r[24:31];
   endtask

   function automatic logic [15:0] crc16_update(input logic [15:0] crc, input logic [7:0] data);
      logic [15:0] c;
      logic fb;
      c = crc;
      for (int i = 7; i >= 0; i--) begin
         fb = c[15] ^ data[i];
         c = {c[14:0], 1'b0};
         if (fb) begin
            c = c ^ 16'h1021;
         end
      end
      return c;
   endfunction

   task automatic reset_values_test();
      logic [0:31] r;
      bus_read(sdcard_pkg::reg_ctrl, r);
      check("divider after reset", r[0:7], 8'hff);
      check("busy after reset", r[23], 1'b0);
      check("chip-select after reset", r[19], 1'b0);
      check("sck pin after reset", sdcard_sck, 1'b0);
      check("mosi pin after reset", sdcard_mosi, 1'b0);
      check("cs pin after reset", sdcard_cs, 1'b0);
      bus_read(sdcard_pkg::reg_crc, r);
      check("num_sdcard field", r[8:11], num_sdcard);
   endtask

   task automatic transfer_test();
      logic [31:0] rnd;
      logic [7:0] tx;
      logic [7:0] reply;
      logic [7:0] rx;
      for (int n = 0; n < 4; n++) begin
         rnd = $random(seed);
         tx = rnd[7:0];
         reply = rnd[15:8];
         xfer_byte(tx, reply, 0, 1'b0, rx);
         check("byte at card", sent_shift, tx);
         check("in_byte", rx, reply);
      end
   endtask

   task automatic wait_mode_test();
      logic [31:0] rnd;
      logic [7:0] reply;
      logic [7:0] rx;
      for (int lead = 1; lead <= 5; lead++) begin
         rnd = $random(seed);
         reply = {1'b0, rnd[6:0]};
         xfer_byte(8'hff, reply, lead, 1'b1, rx);
         check("in_byte after wait", rx, reply);
      end
   endtask

   task automatic crc_test();
      logic [0:31] w;
      logic [0:31] r;
      logic [31:0] rnd;
      logic [7:0] rx;
      logic [15:0] crc;
      // Chip-select goes low first so that the next start opens a new frame.
      w = '0;
      bus_write(sdcard_pkg::reg_ctrl, 4'b0010, w);
      xfer_byte(8'h40, 8'hff, 0, 1'b0, rx);
      for (int n = 0; n < 4; n++) begin
         xfer_byte(8'h00, 8'hff, 0, 1'b0, rx);
      end
      bus_read(sdcard_pkg::reg_crc, r);
      check("crc7 of CMD0", r[0:7], 8'h95);
      w = '0;
      w[31] = 1'b1;
      bus_write(sdcard_pkg::reg_crc, 4'b0011, w);
      bus_read(sdcard_pkg::reg_crc, r);
      check("crc16 cleared", r[16:31], 16'h0000);
      crc = 16'h0000;
      for (int n = 0; n < 4; n++) begin
         rnd = $random(seed);
         xfer_byte(rnd[7:0], 8'hff, 0, 1'b0, rx);
         crc = crc16_update(crc, rnd[7:0]);
      end
      bus_read(sdcard_pkg::reg_crc, r);
      check("crc16 over mosi", r[16:31], crc);
   endtask

   task automatic card_detect_test(input int slot);
      logic [0:31] w;
      logic [0:31] r;
      int base;
      base = 8 + 4 * slot;
      @(posedge clk);
      #1;
      sdcard_cd[slot] = 1'b1;
      repeat (5) @(posedge clk);
      bus_read(sdcard_pkg::reg_ctrl, r);
      check("inserted set", r[base], 1'b1);
      check("cd high", r[base + 3], 1'b1);
      w = '0;
      w[base] = 1'b1;
      bus_write(sdcard_pkg::reg_ctrl, 4'b0100, w);
      bus_read(sdcard_pkg::reg_ctrl, r);
      check("inserted cleared", r[base], 1'b0);
      @(posedge clk);
      #1;
      sdcard_cd[slot] = 1'b0;
      repeat (5) @(posedge clk);
      bus_read(sdcard_pkg::reg_ctrl, r);
      check("removed set", r[base + 1], 1'b1);
      check("cd low", r[base + 3], 1'b0);
      w = '0;
      w[base + 1] = 1'b1;
      bus_write(sdcard_pkg::reg_ctrl, 4'b0100, w);
      bus_read(sdcard_pkg::reg_ctrl, r);
      check("removed cleared", r[base + 1], 1'b0);
      @(posedge clk);
      #1;
      sdcard_wp[slot] = 1'b1;
      repeat (2) @(posedge clk);
      bus_read(sdcard_pkg::reg_ctrl, r);
      check("wp high", r[base + 2], 1'b1);
      @(posedge clk);
      #1;
      sdcard_wp[slot] = 1'b0;
      repeat (2) @(posedge clk);
      bus_read(sdcard_pkg::reg_ctrl, r);
      check("wp low", r[base + 2], 1'b0);
   endtask

   task automatic slot_select_test();
      logic [0:31] w;
      logic [0:31] r;
      w = '0;
      w[15] = 1'b1;
      bus_write(sdcard_pkg::reg_crc, 4'b0100, w);
      check("select pin set", sdcard_select, 1'b1);
      bus_read(sdcard_pkg::reg_crc, r);
      check("select readback set", r[15], 1'b1);
      w[15] = 1'b0;
      bus_write(sdcard_pkg::reg_crc, 4'b0100, w);
      check("select pin clear", sdcard_select, 1'b0);
      bus_read(sdcard_pkg::reg_crc, r);
      check("select readback clear", r[15], 1'b0);
   endtask

   initial begin
      seed = 32'hd6e24270;
      reset = 1'b1;
      adr = 4'b0000;
      cs = 1'b0;
      sel = 4'b0000;
      we = 1'b0;
      d = '0;
      sdcard_cd = 2'b00;
      sdcard_wp = 2'b00;
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;
      reset_values_test();
      transfer_test();
      wait_mode_test();
      crc_test();
      card_detect_test(0);
      card_detect_test(1);
      slot_select_test();
      if (errors == 0) begin
         $display("Simulation completed successfully");
         $finish;
      end else begin
         $display("Simulation failed");
         $fatal(1, "Errors found");
      end
   end

endmodule

`default_nettype wire

//--- verilog.f
sdcard_pkg.sv
sdcard_spi_engine.sv
sdcard_crc.sv
sdcard_detect.sv
sdcard_regs.sv
sdcard_host.sv
tb_sdcard_host.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SD host testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
   --top-module tb_sdcard_host -f verilog.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/Vtb_sdcard_host 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation run exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "Simulation completed successfully"; then
   exit 0
fi
exit 1
